/* verilog/sparse_geom_pkg.sv */
package sparse_geom_pkg;

	//////////////////////////////////////////////////////////////////////
	// Chunk geometry defaults
	//////////////////////////////////////////////////////////////////////

	// Dense positions carried by one write beat
	localparam int DEF_BUS_SIZE = 8;

	// Dense positions held by one chunk
	localparam int DEF_MEM_SIZE = 32;

	// Dense positions per sparsemap segment, as seen by the encoder
	localparam int DEF_SEG_SIZE = 8;

	// A chunk is a whole number of beats and of segments
	localparam int DEF_BEAT_NUM = DEF_MEM_SIZE / DEF_BUS_SIZE;
	localparam int DEF_SEG_NUM = DEF_MEM_SIZE / DEF_SEG_SIZE;

endpackage

/* verilog/sparse_elem_pkg.sv */
package sparse_elem_pkg;

	//////////////////////////////////////////////////////////////////////
	// Operand element payloads
	//////////////////////////////////////////////////////////////////////

	// IFM activation, post-ReLU so never negative
	typedef logic [7:0] act_t;

	// Filter weight, two's complement
	typedef logic signed [7:0] wgt_t;

endpackage

/* verilog/data_chunk.sv */
`timescale 1ns/1ps

module data_chunk
	import sparse_geom_pkg::*;
	import sparse_elem_pkg::*;
#(
	parameter int BUS_SIZE = DEF_BUS_SIZE,
	parameter int MEM_SIZE = DEF_MEM_SIZE,
	parameter int SEG_SIZE = DEF_SEG_SIZE,
	parameter type elem_t = act_t,
	localparam int BEAT_NUM = MEM_SIZE / BUS_SIZE,
	localparam int SEG_NUM = MEM_SIZE / SEG_SIZE,
	localparam int CNT_W = (BEAT_NUM > 1) ? $clog2(BEAT_NUM) : 1,
	localparam int SEG_AW = (SEG_NUM > 1) ? $clog2(SEG_NUM) : 1,
	localparam int POS_W = (SEG_SIZE > 1) ? $clog2(SEG_SIZE) : 1
) (
	input logic clk_i,
	input logic rst_i,

	// Write side, one beat per strobe
	input logic [BUS_SIZE-1:0] wr_sparsemap_i,
	input elem_t [BUS_SIZE-1:0] wr_data_i,
	input logic wr_valid_i,
	input logic [CNT_W-1:0] wr_count_i,
	input logic wr_bank_i,

	// Read side
	input logic rd_bank_i,
	input logic [SEG_AW-1:0] seg_addr_i,
	input logic [POS_W-1:0] match_pos_i,
	input logic match_valid_i,
	input logic seg_last_i,
	input logic chunk_start_i,
	output logic [SEG_SIZE-1:0] rd_segment_o,
	output elem_t rd_data_o
);

	// Dense position width, and packed address width with room for MEM_SIZE itself
	localparam int MEM_AW = (MEM_SIZE > 1) ? $clog2(MEM_SIZE) : 1;
	localparam int ADDR_W = MEM_AW + 1;

	// Two banks so the producer can fill one while the other is read
	logic [MEM_SIZE-1:0] smap_mem [2];
	elem_t data_mem [2][MEM_SIZE];

	logic [MEM_AW-1:0] wr_pos_w;
	logic [MEM_AW-1:0] seg_pos_w;
	logic [MEM_SIZE-1:0] rd_map_w;
	logic [SEG_SIZE-1:0] below_w;
	logic [ADDR_W-1:0] base_r;
	logic [ADDR_W-1:0] data_addr_w;
	elem_t rd_data_r;

	function automatic logic [ADDR_W-1:0] popcount(input logic [SEG_SIZE-1:0] bits);
		logic [ADDR_W-1:0] cnt;
		cnt = '0;
		for (int i = 0; i < SEG_SIZE; i++) begin
			cnt = cnt + ADDR_W'(bits[i]);
		end
		return cnt;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	assign wr_pos_w = MEM_AW'(int'(wr_count_i) * BUS_SIZE);

	// Packed values sit at the same offsets as the beat positions
	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			for (int i = 0; i < BUS_SIZE; i++) begin
				smap_mem[wr_bank_i][wr_pos_w + MEM_AW'(i)] <= wr_sparsemap_i[i];
				data_mem[wr_bank_i][wr_pos_w + MEM_AW'(i)] <= wr_data_i[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sparsemap segment read
	//////////////////////////////////////////////////////////////////////

	assign seg_pos_w = MEM_AW'(int'(seg_addr_i) * SEG_SIZE);
	assign rd_map_w = smap_mem[rd_bank_i];
	assign rd_segment_o = rd_map_w[seg_pos_w +: SEG_SIZE];

	//////////////////////////////////////////////////////////////////////
	// Prefix sum and element read
	//////////////////////////////////////////////////////////////////////

	// Nonzeros seen in all earlier segments of this chunk
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			base_r <= '0;
		end else if (chunk_start_i) begin
			base_r <= '0;
		end else if (seg_last_i) begin
			base_r <= base_r + popcount(rd_segment_o);
		end
	end

	// Bits strictly below the matched position
	assign below_w = (SEG_SIZE'(1) << match_pos_i) - SEG_SIZE'(1);
	assign data_addr_w = base_r + popcount(rd_segment_o & below_w);

	always_ff @(posedge clk_i) begin
		if (match_valid_i) begin
			rd_data_r <= data_mem[rd_bank_i][data_addr_w[MEM_AW-1:0]];
		end
	end

	assign rd_data_o = rd_data_r;

	// A bad sparsemap from the producer would push the prefix sum past the chunk
	a_addr_in_range: assert property (
		@(posedge clk_i) disable iff (rst_i)
		match_valid_i |-> (data_addr_w < ADDR_W'(MEM_SIZE))
	);

endmodule

/* verilog/match_encoder.sv */
`timescale 1ns/1ps

module match_encoder
	import sparse_geom_pkg::*;
#(
	parameter int SEG_SIZE = DEF_SEG_SIZE,
	localparam int POS_W = (SEG_SIZE > 1) ? $clog2(SEG_SIZE) : 1
) (
	input logic clk_i,
	input logic rst_i,
	input logic active_i,
	input logic chunk_start_i,
	input logic [SEG_SIZE-1:0] ifm_segment_i,
	input logic [SEG_SIZE-1:0] filter_segment_i,
	output logic match_valid_o,
	output logic [POS_W-1:0] match_pos_o,
	output logic seg_last_o
);

	logic fresh_r;
	logic [SEG_SIZE-1:0] rem_r;
	logic [SEG_SIZE-1:0] mask_w;
	logic [SEG_SIZE-1:0] next_rem_w;
	logic [POS_W-1:0] pos_w;

	//////////////////////////////////////////////////////////////////////
	// Current mask
	//////////////////////////////////////////////////////////////////////

	// New segment takes the common nonzeros, otherwise what is left over
	assign mask_w = fresh_r ? (ifm_segment_i & filter_segment_i) : rem_r;

	// Drop the lowest set bit
	assign next_rem_w = mask_w & (mask_w - SEG_SIZE'(1));

	// Lowest set position wins
	always_comb begin
		pos_w = '0;
		for (int i = SEG_SIZE - 1; i >= 0; i--) begin
			if (mask_w[i]) begin
				pos_w = POS_W'(i);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Walk state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			fresh_r <= 1'b1;
		end else if (chunk_start_i) begin
			fresh_r <= 1'b1;
		end else if (active_i) begin
			// Next segment starts fresh once this one is used up
			fresh_r <= seg_last_o;
		end
	end

	always_ff @(posedge clk_i) begin
		if (active_i) begin
			rem_r <= next_rem_w;
		end
	end

	assign match_valid_o = active_i && (mask_w != '0);
	assign match_pos_o = pos_w;
	// Zero or one bit left means this cycle finishes the segment
	assign seg_last_o = active_i && (next_rem_w == '0);

	// Both segments must hold still while their remainder is walked
	a_pos_in_mask: assert property (
		@(posedge clk_i) disable iff (rst_i)
		match_valid_o |-> (ifm_segment_i[match_pos_o] && filter_segment_i[match_pos_o])
	);

endmodule

/* verilog/input_selector.sv */
`timescale 1ns/1ps

module input_selector
	import sparse_geom_pkg::*;
	import sparse_elem_pkg::*;
#(
	parameter int BUS_SIZE = DEF_BUS_SIZE,
	parameter int MEM_SIZE = DEF_MEM_SIZE,
	parameter int SEG_SIZE = DEF_SEG_SIZE,
	localparam int BEAT_NUM = MEM_SIZE / BUS_SIZE,
	localparam int SEG_NUM = MEM_SIZE / SEG_SIZE,
	localparam int CNT_W = (BEAT_NUM > 1) ? $clog2(BEAT_NUM) : 1,
	localparam int SEG_AW = (SEG_NUM > 1) ? $clog2(SEG_NUM) : 1
) (
	input logic clk_i,
	input logic rst_i,

	// IFM store write side
	input logic [BUS_SIZE-1:0] ifm_wr_sparsemap_i,
	input act_t [BUS_SIZE-1:0] ifm_wr_data_i,
	input logic ifm_wr_valid_i,
	input logic [CNT_W-1:0] ifm_wr_count_i,
	input logic ifm_wr_bank_i,
	input logic ifm_rd_bank_i,

	// Filter store write side
	input logic [BUS_SIZE-1:0] filter_wr_sparsemap_i,
	input wgt_t [BUS_SIZE-1:0] filter_wr_data_i,
	input logic filter_wr_valid_i,
	input logic [CNT_W-1:0] filter_wr_count_i,
	input logic filter_wr_bank_i,
	input logic filter_rd_bank_i,

	// Run control
	input logic run_valid_i,
	input logic chunk_start_i,
	input logic [SEG_AW-1:0] last_segment_i,

	output act_t ifm_data_o,
	output wgt_t filter_data_o,
	output logic data_valid_o,
	output logic chunk_end_o
);

	localparam int POS_W = (SEG_SIZE > 1) ? $clog2(SEG_SIZE) : 1;

	logic running_r;
	logic run_active_w;
	logic [SEG_AW-1:0] seg_addr_r;
	logic [SEG_SIZE-1:0] ifm_segment_w;
	logic [SEG_SIZE-1:0] filter_segment_w;
	logic match_valid_w;
	logic [POS_W-1:0] match_pos_w;
	logic seg_last_w;
	logic data_valid_r;

	//////////////////////////////////////////////////////////////////////
	// Operand stores and match walk
	//////////////////////////////////////////////////////////////////////

	data_chunk #(
		.BUS_SIZE(BUS_SIZE),
		.MEM_SIZE(MEM_SIZE),
		.SEG_SIZE(SEG_SIZE),
		.elem_t(act_t)
	) u_chunk_ifm (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wr_sparsemap_i(ifm_wr_sparsemap_i),
		.wr_data_i(ifm_wr_data_i),
		.wr_valid_i(ifm_wr_valid_i),
		.wr_count_i(ifm_wr_count_i),
		.wr_bank_i(ifm_wr_bank_i),
		.rd_bank_i(ifm_rd_bank_i),
		.seg_addr_i(seg_addr_r),
		.match_pos_i(match_pos_w),
		.match_valid_i(match_valid_w),
		.seg_last_i(seg_last_w),
		.chunk_start_i(chunk_start_i),
		.rd_segment_o(ifm_segment_w),
		.rd_data_o(ifm_data_o)
	);

	data_chunk #(
		.BUS_SIZE(BUS_SIZE),
		.MEM_SIZE(MEM_SIZE),
		.SEG_SIZE(SEG_SIZE),
		.elem_t(wgt_t)
	) u_chunk_filter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wr_sparsemap_i(filter_wr_sparsemap_i),
		.wr_data_i(filter_wr_data_i),
		.wr_valid_i(filter_wr_valid_i),
		.wr_count_i(filter_wr_count_i),
		.wr_bank_i(filter_wr_bank_i),
		.rd_bank_i(filter_rd_bank_i),
		.seg_addr_i(seg_addr_r),
		.match_pos_i(match_pos_w),
		.match_valid_i(match_valid_w),
		.seg_last_i(seg_last_w),
		.chunk_start_i(chunk_start_i),
		.rd_segment_o(filter_segment_w),
		.rd_data_o(filter_data_o)
	);

	match_encoder #(
		.SEG_SIZE(SEG_SIZE)
	) u_match_encoder (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.active_i(run_active_w),
		.chunk_start_i(chunk_start_i),
		.ifm_segment_i(ifm_segment_w),
		.filter_segment_i(filter_segment_w),
		.match_valid_o(match_valid_w),
		.match_pos_o(match_pos_w),
		.seg_last_o(seg_last_w)
	);

	//////////////////////////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////////////////////////

	// Idle out of reset until a chunk is started
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			running_r <= 1'b0;
		end else if (chunk_start_i) begin
			running_r <= 1'b1;
		end else if (chunk_end_o) begin
			running_r <= 1'b0;
		end
	end

	assign run_active_w = run_valid_i && running_r;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			seg_addr_r <= '0;
		end else if (chunk_start_i) begin
			seg_addr_r <= '0;
		end else if (seg_last_w) begin
			seg_addr_r <= seg_addr_r + SEG_AW'(1);
		end
	end

	assign chunk_end_o = seg_last_w && (seg_addr_r == last_segment_i);

	// Elements land one clock after the match
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			data_valid_r <= 1'b0;
		end else begin
			data_valid_r <= match_valid_w;
		end
	end

	assign data_valid_o = data_valid_r;

	a_start_when_idle: assert property (
		@(posedge clk_i) disable iff (rst_i)
		chunk_start_i |-> !running_r
	);

endmodule

/* verification/input_selector_tb.sv */
`timescale 1ns/1ps

module input_selector_tb
	import sparse_geom_pkg::*;
	import sparse_elem_pkg::*;
();

	localparam int BUS_SIZE = DEF_BUS_SIZE;
	localparam int MEM_SIZE = DEF_MEM_SIZE;
	localparam int SEG_SIZE = DEF_SEG_SIZE;
	localparam int BEAT_NUM = MEM_SIZE / BUS_SIZE;
	localparam int SEG_NUM = MEM_SIZE / SEG_SIZE;
	localparam int CNT_W = (BEAT_NUM > 1) ? $clog2(BEAT_NUM) : 1;
	localparam int SEG_AW = (SEG_NUM > 1) ? $clog2(SEG_NUM) : 1;
	localparam int TIMEOUT_CYCLES = 400;

	logic clk_i;
	logic rst_i;
	logic [BUS_SIZE-1:0] ifm_wr_sparsemap_i;
	act_t [BUS_SIZE-1:0] ifm_wr_data_i;
	logic ifm_wr_valid_i;
	logic [CNT_W-1:0] ifm_wr_count_i;
	logic ifm_wr_bank_i;
	logic ifm_rd_bank_i;
	logic [BUS_SIZE-1:0] filter_wr_sparsemap_i;
	wgt_t [BUS_SIZE-1:0] filter_wr_data_i;
	logic filter_wr_valid_i;
	logic [CNT_W-1:0] filter_wr_count_i;
	logic filter_wr_bank_i;
	logic filter_rd_bank_i;
	logic run_valid_i;
	logic chunk_start_i;
	logic [SEG_AW-1:0] last_segment_i;
	act_t ifm_data_o;
	wgt_t filter_data_o;
	logic data_valid_o;
	logic chunk_end_o;

	// Dense maps and packed values per bank, as the producer wrote them
	logic [MEM_SIZE-1:0] ifm_map_m [2];
	logic [MEM_SIZE-1:0] filter_map_m [2];
	act_t ifm_pack_m [2][MEM_SIZE];
	wgt_t filter_pack_m [2][MEM_SIZE];

	act_t exp_ifm_q [$];
	wgt_t exp_filter_q [$];
	act_t exp_ifm_front;
	wgt_t exp_filter_front;
	int exp_count;
	int ends_seen;
	logic end_armed;
	logic end_d1;
	logic end_d2;
	logic stall_en;
	integer seed;

	input_selector #(
		.BUS_SIZE(BUS_SIZE),
		.MEM_SIZE(MEM_SIZE),
		.SEG_SIZE(SEG_SIZE)
	) input_selector_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge clk_i);
		#1;
	endtask

	function automatic logic [7:0] nonzero_byte();
		logic [7:0] v;
		v = 8'($random(seed));
		if (v == 8'h00) begin
			v = 8'h01;
		end
		return v;
	endfunction

	function automatic int ones_below(input logic [MEM_SIZE-1:0] map, input int pos);
		int cnt;
		cnt = 0;
		for (int q = 0; q < pos; q++) begin
			cnt += int'(map[q]);
		end
		return cnt;
	endfunction

	function automatic void refresh_front();
		exp_count = exp_ifm_q.size();
		if (exp_count > 0) begin
			exp_ifm_front = exp_ifm_q[0];
			exp_filter_front = exp_filter_q[0];
		end
	endfunction

	// Random dense maps, packed from address 0 and written beat by beat
	task automatic load_chunk(input logic bank, input logic disjoint);
		int n_ifm;
		int n_filter;
		n_ifm = 0;
		n_filter = 0;
		for (int p = 0; p < MEM_SIZE; p++) begin
			ifm_map_m[bank][p] = ($random(seed) & 3) != 0;
			if (disjoint) begin
				filter_map_m[bank][p] = !ifm_map_m[bank][p];
			end else begin
				filter_map_m[bank][p] = ($random(seed) & 3) != 0;
			end
			ifm_pack_m[bank][p] = '0;
			filter_pack_m[bank][p] = '0;
		end
		for (int p = 0; p < MEM_SIZE; p++) begin
			if (ifm_map_m[bank][p]) begin
				ifm_pack_m[bank][n_ifm] = act_t'(nonzero_byte());
				n_ifm++;
			end
			if (filter_map_m[bank][p]) begin
				filter_pack_m[bank][n_filter] = wgt_t'(nonzero_byte());
				n_filter++;
			end
		end
		ifm_wr_bank_i = bank;
		filter_wr_bank_i = bank;
		for (int k = 0; k < BEAT_NUM; k++) begin
			ifm_wr_valid_i = 1'b1;
			filter_wr_valid_i = 1'b1;
			ifm_wr_count_i = CNT_W'(k);
			filter_wr_count_i = CNT_W'(k);
			ifm_wr_sparsemap_i = ifm_map_m[bank][k*BUS_SIZE +: BUS_SIZE];
			filter_wr_sparsemap_i = filter_map_m[bank][k*BUS_SIZE +: BUS_SIZE];
			for (int i = 0; i < BUS_SIZE; i++) begin
				ifm_wr_data_i[i] = ifm_pack_m[bank][k*BUS_SIZE + i];
				filter_wr_data_i[i] = filter_pack_m[bank][k*BUS_SIZE + i];
			end
			next_cycle();
		end
		ifm_wr_valid_i = 1'b0;
		filter_wr_valid_i = 1'b0;
	endtask

	// Common nonzero positions up to the last segment, lowest first
	task automatic build_model(input logic bank, input int last_seg);
		for (int p = 0; p < (last_seg + 1) * SEG_SIZE; p++) begin
			if (ifm_map_m[bank][p] && filter_map_m[bank][p]) begin
				exp_ifm_q.push_back(ifm_pack_m[bank][ones_below(ifm_map_m[bank], p)]);
				exp_filter_q.push_back(filter_pack_m[bank][ones_below(filter_map_m[bank], p)]);
			end
		end
		refresh_front();
	endtask

	task automatic run_chunk(input logic bank, input int last_seg);
		int start_ends;
		int wait_cnt;
		build_model(bank, last_seg);
		ifm_rd_bank_i = bank;
		filter_rd_bank_i = bank;
		last_segment_i = SEG_AW'(last_seg);
		end_armed = 1'b1;
		start_ends = ends_seen;
		chunk_start_i = 1'b1;
		next_cycle();
		chunk_start_i = 1'b0;
		wait_cnt = 0;
		while (ends_seen == start_ends && wait_cnt < TIMEOUT_CYCLES) begin
			next_cycle();
			wait_cnt++;
		end
		if (ends_seen == start_ends) begin
			fail_run("Timed out waiting for chunk_end_o after chunk_start_i");
		end
		// Room for the last pair and the drain check
		next_cycle();
		next_cycle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Scoreboard and checks
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_i) begin
		if (!rst_i) begin
			if (data_valid_o && exp_ifm_q.size() > 0) begin
				void'(exp_ifm_q.pop_front());
				void'(exp_filter_q.pop_front());
				refresh_front();
			end
			if (chunk_end_o) begin
				ends_seen++;
				end_armed = 1'b0;
			end
		end
	end

	// Last data_valid_o may trail chunk_end_o by one cycle
	always @(posedge clk_i) begin
		if (rst_i) begin
			end_d1 <= 1'b0;
			end_d2 <= 1'b0;
		end else begin
			end_d1 <= chunk_end_o;
			end_d2 <= end_d1;
		end
	end

	// Back-pressure, random when stalls are on
	always @(posedge clk_i) begin
		#1;
		if (stall_en) begin
			run_valid_i = ($random(seed) & 3) != 0;
		end else begin
			run_valid_i = 1'b1;
		end
	end

	a_ifm_data: assert property (
		@(posedge clk_i) disable iff (rst_i)
		data_valid_o |-> (ifm_data_o == exp_ifm_front)
	) else fail_run($sformatf("FAILED time=%0t signal=ifm_data_o expected=%h actual=%h",
		$time, $sampled(exp_ifm_front), $sampled(ifm_data_o)));

	a_filter_data: assert property (
		@(posedge clk_i) disable iff (rst_i)
		data_valid_o |-> (filter_data_o == exp_filter_front)
	) else fail_run($sformatf("FAILED time=%0t signal=filter_data_o expected=%h actual=%h",
		$time, $sampled(exp_filter_front), $sampled(filter_data_o)));

	a_valid_expected: assert property (
		@(posedge clk_i) disable iff (rst_i)
		data_valid_o |-> (exp_count > 0)
	) else fail_run("data_valid_o was high while no pair was expected");

	a_end_expected: assert property (
		@(posedge clk_i) disable iff (rst_i)
		chunk_end_o |-> end_armed
	) else fail_run("chunk_end_o pulsed without a running chunk or more than once");

	a_queue_drained: assert property (
		@(posedge clk_i) disable iff (rst_i)
		end_d2 |-> (exp_count == 0)
	) else fail_run("Expected pairs were still missing after chunk_end_o");

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 32'hbbe4_15b5;
		rst_i = 1'b1;
		ifm_wr_sparsemap_i = '0;
		ifm_wr_data_i = '0;
		ifm_wr_valid_i = 1'b0;
		ifm_wr_count_i = '0;
		ifm_wr_bank_i = 1'b0;
		ifm_rd_bank_i = 1'b0;
		filter_wr_sparsemap_i = '0;
		filter_wr_data_i = '0;
		filter_wr_valid_i = 1'b0;
		filter_wr_count_i = '0;
		filter_wr_bank_i = 1'b0;
		filter_rd_bank_i = 1'b0;
		run_valid_i = 1'b0;
		chunk_start_i = 1'b0;
		last_segment_i = '0;
		exp_count = 0;
		ends_seen = 0;
		end_armed = 1'b0;
		stall_en = 1'b0;
		repeat (8) @(posedge clk_i);
		#1;
		rst_i = 1'b0;

		// Idle after reset, no chunk started
		repeat (10) next_cycle();

		load_chunk(1'b0, 1'b0);
		run_chunk(1'b0, SEG_NUM - 1);

		// Early last segment
		load_chunk(1'b1, 1'b0);
		run_chunk(1'b1, 1);

		// No common nonzeros at all
		load_chunk(1'b0, 1'b1);
		run_chunk(1'b0, SEG_NUM - 1);

		stall_en = 1'b1;
		repeat (4) begin
			load_chunk(1'b1, 1'b0);
			run_chunk(1'b1, SEG_NUM - 1);
		end

		// Fill the other bank while this one is read
		load_chunk(1'b0, 1'b0);
		fork
			run_chunk(1'b0, SEG_NUM - 1);
			begin
				repeat (2) next_cycle();
				load_chunk(1'b1, 1'b0);
			end
		join
		run_chunk(1'b1, SEG_NUM - 1);

		if (exp_count != 0) begin
			fail_run("Expected pairs were left over at the end of the run");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

/* sim.f */
verilog/sparse_geom_pkg.sv
verilog/sparse_elem_pkg.sv
verilog/data_chunk.sv
verilog/match_encoder.sv
verilog/input_selector.sv
verification/input_selector_tb.sv

/* Makefile */
# Verilator build for the operand selector testbench

VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := input_selector_tb
FILE_LIST := sim.f
OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
PASS_MSG := ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# Pass or fail comes from the simulation output alone
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	printf '%s\n' "$$out"; \
	if printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
